/* compile.f */
design/fdc_bus_pkg.sv
design/fdc_drive_pkg.sv
design/mcu_bus_interface.sv
design/register_file.sv
design/sram_write_controller.sv
design/disc_timebase.sv
design/step_controller.sv
design/disc_analyser_top.sv
testbench/tb_disc_analyser.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module tb_disc_analyser -Mdir obj_dir -o sim_disc_analyser
./obj_dir/sim_disc_analyser 2>&1 | tee sim.log
if grep -q "Something failed" sim.log; then
	echo "Simulation reported an error, see sim.log"
	exit 1
fi
echo "Simulation passed"

/* testbench/tb_disc_analyser.sv */
`timescale 1ns/1ns

module tb_disc_analyser import fdc_bus_pkg::*, fdc_drive_pkg::*; ();

	localparam int TICK_CYCLES	= 20;			// Short ticks for simulation
	localparam int CLK_PERIOD	= 100;
	localparam int HOLD			= 8;			// Cycles per bus level
	localparam int N_BYTES		= 16;
	localparam int N_STEP		= 4;
	localparam int MAX_COUNT	= 15;
	localparam int MAX_RATE		= 7;
	localparam int MAX_PERIOD	= 60;			// Index period in ticks
	localparam int N_TRANS		= 64 + 2*N_BYTES + 8*N_STEP;		// Bus accesses, upper bound
	localparam int STEP_TICKS	= N_STEP*(MAX_COUNT+1)*(MAX_RATE+2) + 2*MAX_PERIOD;
	localparam int LIMIT_CYCLES	= N_TRANS*20 + STEP_TICKS*TICK_CYCLES;

	logic			CLK_MASTER, reset;
	host_byte_t		pmd_in, pmd_out;
	logic			pmd_oe, pmall, pmrd, pmwr;
	sram_bus_t		sram;
	host_byte_t		sram_dq_in = '0;
	logic			fd_index, fd_wrprot, fd_rdy, fd_dens_in;
	logic			fd_track0 = 1'b1;
	logic			fd_step, fd_dir, fd_dens_out, fd_inuse, fd_motena, fd_sidesel;
	logic [3:0]		fd_drvsel;

	host_byte_t		sram_mem [sram_addr_t];		// Only written locations
	int				head_pos = 5;				// Drive starts off track 0
	int				step_pulses = 0;
	logic			step_prev = 1'b1;

	disc_analyser_top #(.TICK_CYCLES(TICK_CYCLES)) i_disc_analyser_top (.*);

	initial begin
		CLK_MASTER = 1'b0;
		forever #(CLK_PERIOD/2) CLK_MASTER = ~CLK_MASTER;
	end

	//////////////////////////////
	// SRAM and drive model
	function automatic host_byte_t fill_byte(sram_addr_t a);
		return a[7:0] ^ a[15:8] ^ {5'b00000, a[18:16]} ^ 8'h5A;		// Unwritten cells
	endfunction

	always @(posedge CLK_MASTER) begin
		if (!reset) begin
			if (!sram.we_n) begin							// WE low for one cycle
				if (!sram.oe_n) begin
					$display("SRAM write enable and output enable were active together");
					stop_on_error();
				end
				sram_mem[sram.addr] = sram.dq_out;
			end
			if (sram.oe_n) sram_dq_in <= 8'hFF;			// Outputs off, bus pulled up
			else if (sram_mem.exists(sram.addr)) sram_dq_in <= sram_mem[sram.addr];
			else sram_dq_in <= fill_byte(sram.addr);
			step_prev <= fd_step;
			if (step_prev && !fd_step) begin					// Head moves on pulse start
				head_pos	<= fd_dir ? head_pos - 1 : head_pos + 1;
				step_pulses	<= step_pulses + 1;
			end
			fd_track0 <= (head_pos != 0);						// Active low at track 0
		end
	end

	//////////////////////////////
	// Checks
	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_byte(input string name, input host_byte_t got, input host_byte_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_drive(input drive_ctrl_u exp);
		drive_ctrl_u pins;
		pins.raw = {fd_sidesel, fd_motena, fd_drvsel, fd_inuse, fd_dens_out};
		if (pins.raw !== ~exp.raw) begin		// Pins are the inverted register
			$display("FAILED at %0t ns: drive pins = %h, expected %h", $time, pins.raw, ~exp.raw);
			stop_on_error();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_period(input logic [15:0] got, input int exp);
		if ((int'(got) < exp - 1) || (int'(got) > exp + 1)) begin	// Tick phase is free
			$display("FAILED at %0t ns: index period = %0d, expected %0d +/- 1", $time, got, exp);
			stop_on_error();
		end
	endtask

	//////////////////////////////
	// MCU bus
	task automatic bus_addr(input reg_addr_e a);
		@(posedge CLK_MASTER);
		pmd_in	<= a;
		pmall	<= 1'b1;
		repeat (HOLD) @(posedge CLK_MASTER);
		pmall	<= 1'b0;
	endtask

	task automatic bus_write(input host_byte_t d);
		@(posedge CLK_MASTER);
		pmd_in	<= d;
		pmwr	<= 1'b1;
		repeat (HOLD) @(posedge CLK_MASTER);
		pmwr	<= 1'b0;
		repeat (HOLD) @(posedge CLK_MASTER);			// Room for the SRAM write sequence
	endtask

	task automatic bus_read(output host_byte_t d);
		@(posedge CLK_MASTER);
		pmrd <= 1'b1;
		repeat (HOLD - 1) @(posedge CLK_MASTER);
		@(negedge CLK_MASTER);
		d = pmd_out;
		check_level("pmd_oe", pmd_oe, 1'b1);
		@(posedge CLK_MASTER);
		pmrd <= 1'b0;
		repeat (HOLD) @(posedge CLK_MASTER);			// Read end and latch reopen
		check_level("pmd_oe", pmd_oe, 1'b0);			// Bus handed back to the MCU
	endtask

	task automatic reg_write(input reg_addr_e a, input host_byte_t d);
		bus_addr(a);
		bus_write(d);
	endtask

	task automatic reg_read(input reg_addr_e a, output host_byte_t d);
		bus_addr(a);
		bus_read(d);
	endtask

	task automatic set_sram_addr(input sram_addr_t a);
		reg_write(REG_SRAM_ADDR_LO, a[7:0]);
		reg_write(REG_SRAM_ADDR_HI, a[15:8]);
		reg_write(REG_SRAM_ADDR_UP, {5'b00000, a[18:16]});
	endtask

	task automatic get_sram_addr(output sram_addr_t a);
		host_byte_t b0, b1, b2;
		reg_read(REG_SRAM_ADDR_LO, b0);
		reg_read(REG_SRAM_ADDR_HI, b1);
		reg_read(REG_SRAM_ADDR_UP, b2);
		a = {b2[2:0], b1, b0};
	endtask

	task automatic pulse_index();
		@(posedge CLK_MASTER);
		fd_index <= 1'b1;
		repeat (4) @(posedge CLK_MASTER);
		fd_index <= 1'b0;
	endtask

	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
		stop_on_error();
	end

	//////////////////////////////
	// Test sequence
	initial begin
		host_byte_t		rd, hi, scratch, rate;
		host_byte_t		wr_bytes [N_BYTES];
		sram_addr_t		start, got_addr, loc;
		drive_ctrl_u	dc;
		step_cmd_t		cmd;
		int				pos_before, pulses_before, exp_pulses, period;
		void'($urandom(22));
		reset = 1'b1;
		pmd_in = '0;
		pmall = 1'b0;
		pmrd = 1'b0;
		pmwr = 1'b0;
		fd_index = 1'b0;
		fd_wrprot = 1'b1;
		fd_rdy = 1'b1;
		fd_dens_in = 1'b1;
		repeat (5) @(posedge CLK_MASTER);
		reset <= 1'b0;

		// Constants and bus test registers
		reg_read(REG_DRIVE_CTRL, rd);
		check_byte("type low", rd, 8'h55);
		reg_read(REG_TYPE_HI, rd);
		check_byte("type high", rd, 8'hDD);
		reg_read(REG_VER_LO, rd);
		check_byte("version low", rd, 8'h1F);
		reg_read(REG_VER_HI, rd);
		check_byte("version high", rd, 8'h00);
		scratch = 8'($urandom);
		reg_write(REG_SCRATCH, scratch);
		reg_read(REG_SCRATCH, rd);
		check_byte("scratchpad", rd, scratch);
		reg_read(REG_SCRATCH_INV, rd);
		check_byte("scratchpad inverse", rd, ~scratch);
		reg_read(REG_FIXED_55, rd);
		check_byte("fixed 0x55", rd, 8'h55);
		reg_read(REG_FIXED_AA, rd);
		check_byte("fixed 0xAA", rd, 8'hAA);

		// SRAM writes, one byte per data write
		start = sram_addr_t'($urandom);
		set_sram_addr(start);
		bus_addr(REG_SRAM_DATA);
		for (int i = 0; i < N_BYTES; i++) begin
			wr_bytes[i] = 8'($urandom);
			bus_write(wr_bytes[i]);
		end
		get_sram_addr(got_addr);
		check_addr("sram address after writes", got_addr, start + sram_addr_t'(N_BYTES));
		for (int i = 0; i < N_BYTES; i++) begin
			loc = start + sram_addr_t'(i);
			if (!sram_mem.exists(loc)) begin
				$display("No SRAM write reached address %h", loc);
				stop_on_error();
			end
			check_byte("sram model cell", sram_mem[loc], wr_bytes[i]);
		end

		// SRAM reads with auto-increment
		set_sram_addr(start);
		bus_addr(REG_SRAM_DATA);
		for (int i = 0; i < N_BYTES; i++) begin
			bus_read(rd);
			check_byte("sram read data", rd, sram_mem[start + sram_addr_t'(i)]);
		end
		get_sram_addr(got_addr);
		check_addr("sram address after reads", got_addr, start + sram_addr_t'(N_BYTES));

		// Drive control pins
		dc.raw = 8'($urandom);
		reg_write(REG_DRIVE_CTRL, dc.raw);
		check_drive(dc);

		// Head stepping
		for (int s = 0; s < N_STEP; s++) begin
			rate = 8'($urandom_range(0, MAX_RATE));
			cmd = step_cmd_t'(8'($urandom));
			cmd.count = 7'($urandom_range(0, MAX_COUNT));
			pos_before = head_pos;
			pulses_before = step_pulses;
			if (cmd.inward || (int'(cmd.count) < pos_before)) exp_pulses = int'(cmd.count);
			else exp_pulses = pos_before;					// Stops at track 0
			reg_write(REG_STEP_RATE, rate);
			reg_write(REG_STEP_CMD, cmd);
			bus_addr(REG_STATUS);
			do begin
				bus_read(rd);
			end while (rd[2]);								// Stepping bit
			check_count("step pulses", step_pulses - pulses_before, exp_pulses);
			check_count("head position", head_pos,
				cmd.inward ? pos_before + exp_pulses : pos_before - exp_pulses);
			check_level("fd_dir", fd_dir, ~cmd.inward);
			check_byte("status", rd, {1'b0, (head_pos != 0), 3'b111, 1'b0, 2'b00});
		end

		// Index period in ticks
		period = $urandom_range(3, MAX_PERIOD);
		pulse_index();
		repeat (period * TICK_CYCLES - 5) @(posedge CLK_MASTER);
		pulse_index();
		repeat (HOLD) @(posedge CLK_MASTER);			// Through the index synchroniser
		reg_read(REG_INDEX_HI, hi);
		reg_read(REG_INDEX_LO, rd);
		check_period({hi, rd}, period);

		$display("Everything OK");
		$finish;
	end

endmodule

/* design/disc_analyser_top.sv */
`timescale 1ns/1ns

module disc_analyser_top import fdc_bus_pkg::*, fdc_drive_pkg::*; #(
	parameter int TICK_CYCLES = 25000
) (
	input	logic			CLK_MASTER,
	input	logic			reset,
	// MCU bus
	input	host_byte_t	pmd_in,
	output	host_byte_t	pmd_out,
	output	logic			pmd_oe,
	input	logic			pmall,
	input	logic			pmrd,
	input	logic			pmwr,
	// SRAM
	output	sram_bus_t	sram,
	input	host_byte_t	sram_dq_in,
	// Drive inputs, active low
	input	logic			fd_index,
	input	logic			fd_track0,
	input	logic			fd_wrprot,
	input	logic			fd_rdy,
	input	logic			fd_dens_in,
	// Drive outputs, active low
	output	logic			fd_step,
	output	logic			fd_dir,
	output	logic			fd_dens_out,
	output	logic			fd_inuse,
	output	logic [3:0]	fd_drvsel,
	output	logic			fd_motena,
	output	logic			fd_sidesel
);

	host_access_t	host;
	drive_status_t	status;
	host_byte_t		step_rate;
	step_cmd_t		step_cmd;
	logic [15:0]	index_period;
	logic			sram_wr, step_go, stepping, tick;

	assign pmd_oe = pmrd;						// MCU owns the bus unless reading
	assign status = '{index: fd_index, track0: fd_track0, wrprot: fd_wrprot,
		ready: fd_rdy, density: fd_dens_in, stepping: stepping};

	mcu_bus_interface i_mcu_bus_interface (
		.CLK_MASTER, .reset, .pmd_in, .pmall, .pmrd, .pmwr, .host);

	register_file i_register_file (
		.CLK_MASTER, .reset, .host, .pmd_out, .sram_dq_in, .sram_a(sram.addr), .sram_wr,
		.index_period, .step_rate, .step_cmd, .step_go, .status, .fd_dens_out, .fd_inuse,
		.fd_motena, .fd_sidesel, .fd_drvsel);

	sram_write_controller i_sram_write_controller (
		.CLK_MASTER, .reset, .host, .sram_wr, .sram);

	disc_timebase #(.TICK_CYCLES(TICK_CYCLES)) i_disc_timebase (
		.CLK_MASTER, .reset, .fd_index, .host, .tick, .index_period);

	step_controller i_step_controller (
		.CLK_MASTER, .reset, .tick, .step_go, .fd_track0, .step_rate, .step_cmd,
		.fd_step, .fd_dir, .stepping);

endmodule

/* design/step_controller.sv */
`timescale 1ns/1ns

module step_controller import fdc_bus_pkg::*, fdc_drive_pkg::*; (
	input	logic			CLK_MASTER,
	input	logic			reset,
	input	logic			tick,					// 250 us
	input	logic			step_go,
	input	logic			fd_track0,				// Active low
	input	host_byte_t	step_rate,
	input	step_cmd_t	step_cmd,
	output	logic			fd_step,				// Active low, one tick
	output	logic			fd_dir,					// Low steps inward
	output	logic			stepping
);

	host_byte_t	rate_cnt;						// Ticks to the next pulse
	host_byte_t	spacing;
	logic [6:0]	steps_left;

	// Rate 0 still leaves one idle tick between pulses
	assign spacing = (step_rate == 8'd0) ? 8'd1 : step_rate;

	//////////////////////////////
	// Pulse sequencer
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			rate_cnt	<= '0;
			steps_left	<= '0;
			fd_step		<= 1'b1;
			fd_dir		<= 1'b1;
			stepping	<= 1'b0;
		end else if (step_go) begin
			rate_cnt	<= '0;						// First pulse on the next tick
			steps_left	<= step_cmd.count;
			fd_dir		<= ~step_cmd.inward;
			fd_step		<= 1'b1;
			stepping	<= (step_cmd.count != 7'd0);
		end else if (tick && stepping) begin
			if (!fd_step) begin
				fd_step <= 1'b1;						// End of pulse
				if (steps_left == 7'd0) stepping <= 1'b0;		// That was the last one
			end
			if (rate_cnt != 8'd0) begin
				rate_cnt <= rate_cnt - 8'd1;
			end else if (fd_dir && !fd_track0) begin
				// Outward at track 0, drop the rest
				steps_left	<= '0;
				stepping	<= 1'b0;
			end else begin
				fd_step		<= 1'b0;
				steps_left	<= steps_left - 7'd1;
				rate_cnt	<= spacing;
			end
		end
	end

	a_step_only_when_busy: assert property (@(posedge CLK_MASTER) disable iff (reset)
		!fd_step |-> stepping);

endmodule

/* design/disc_timebase.sv */
`timescale 1ns/1ns

module disc_timebase import fdc_bus_pkg::*; #(
	parameter int TICK_CYCLES = 25000		// Clocks per 250 us
) (
	input	logic				CLK_MASTER,
	input	logic				reset,
	input	logic				fd_index,
	input	host_access_t	host,
	output	logic				tick,
	output	logic [15:0]	index_period
);

	localparam int TW = $clog2(TICK_CYCLES);

	logic [TW-1:0]	tick_cnt;
	logic [2:0]		idx_sync;					// Two sync flops plus edge history
	logic [15:0]	period_cnt;
	logic [15:0]	period_lat;
	logic [7:0]		period_low;

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			tick_cnt		<= '0;
			tick			<= 1'b0;
			idx_sync		<= '0;
			period_cnt		<= '0;
			period_lat		<= '0;
		end else begin
			tick		<= (tick_cnt == TW'(TICK_CYCLES - 1));
			tick_cnt	<= (tick_cnt == TW'(TICK_CYCLES - 1)) ? '0 : tick_cnt + 1'b1;
			idx_sync	<= {idx_sync[1:0], fd_index};
			if (idx_sync[1] && !idx_sync[2]) begin		// Index rising edge
				period_lat	<= period_cnt;
				period_cnt	<= '0;
			end else if (tick && (period_cnt != 16'hFFFF)) begin
				period_cnt	<= period_cnt + 16'd1;			// Saturates when no disc
			end
		end
	end

	// Low byte frozen when the high byte read completes
	always_ff @(posedge CLK_MASTER) begin
		if (host.rd_end && (host.addr == REG_INDEX_HI)) period_low <= period_lat[7:0];
	end

	assign index_period = {period_lat[15:8], period_low};

endmodule

/* design/sram_write_controller.sv */
`timescale 1ns/1ns

module sram_write_controller import fdc_bus_pkg::*, fdc_drive_pkg::*; (
	input	logic				CLK_MASTER,
	input	logic				reset,
	input	host_access_t	host,
	input	logic				sram_wr,
	output	sram_bus_t		sram
);

	typedef enum logic [2:0] {
		MWC_IDLE,						// OE active, waiting for a byte
		MWC_OE_OFF,					// Release the SRAM outputs
		MWC_WE_LOW,
		MWC_WE_HIGH,
		MWC_INC						// Step to the next location
	} mwc_state_e;

	mwc_state_e	state, state_next;
	sram_addr_t	addr;
	logic [7:0]	wr_data;
	logic			we_n, oe_n;
	logic			rd_inc;

	assign rd_inc = host.rd_end && (host.addr == REG_SRAM_DATA);		// After each 0x03 read

	//////////////////////////////
	// Write sequencer
	always_comb begin
		state_next = state;
		case (state)
			MWC_IDLE:		if (sram_wr) state_next = MWC_OE_OFF;
			MWC_OE_OFF:	state_next = MWC_WE_LOW;
			MWC_WE_LOW:	state_next = MWC_WE_HIGH;
			MWC_WE_HIGH:	state_next = MWC_INC;
			default:		state_next = MWC_IDLE;
		endcase
	end

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state	<= MWC_IDLE;
			we_n	<= 1'b1;
			oe_n	<= 1'b1;						// Goes active on the first cycle out of reset
			addr	<= '0;
		end else begin
			state	<= state_next;
			we_n	<= (state_next != MWC_WE_LOW);		// Low for one cycle
			oe_n	<= (state_next != MWC_IDLE);
			// Address counter, byte loads win over increments
			if (host.wr && (host.addr == REG_SRAM_ADDR_LO)) addr[7:0] <= host.data;
			else if (host.wr && (host.addr == REG_SRAM_ADDR_HI)) addr[15:8] <= host.data;
			else if (host.wr && (host.addr == REG_SRAM_ADDR_UP)) addr[18:16] <= host.data[2:0];
			else if ((state == MWC_INC) || rd_inc) addr <= addr + sram_addr_t'(1);
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if ((state == MWC_IDLE) && sram_wr) wr_data <= host.data;		// Still on the bus
	end

	assign sram = '{addr: addr, dq_out: wr_data, we_n: we_n, oe_n: oe_n};

	// MCU must space its data writes past the whole sequence
	a_wr_when_idle: assert property (@(posedge CLK_MASTER) disable iff (reset)
		sram_wr |-> (state == MWC_IDLE));

endmodule

/* design/register_file.sv */
`timescale 1ns/1ns

module register_file import fdc_bus_pkg::*, fdc_drive_pkg::*; (
	input	logic				CLK_MASTER,
	input	logic				reset,
	input	host_access_t	host,
	output	host_byte_t		pmd_out,
	input	host_byte_t		sram_dq_in,
	input	sram_addr_t		sram_a,
	output	logic				sram_wr,			// Byte for SRAM, one cycle
	input	logic [15:0]	index_period,
	output	host_byte_t		step_rate,
	output	step_cmd_t		step_cmd,
	output	logic				step_go,
	input	drive_status_t	status,
	output	logic				fd_dens_out,
	output	logic				fd_inuse,
	output	logic				fd_motena,
	output	logic				fd_sidesel,
	output	logic [3:0]		fd_drvsel
);

	drive_ctrl_u	drive_ctrl;
	host_byte_t		scratch;
	host_byte_t		sram_rd_lat;				// Held for the MCU while it reads 0x03
	logic [1:0]		rd_end_d;					// Read end at 0x03, delayed
	logic				sram_rd_open;

	//////////////////////////////
	// Write decode
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			drive_ctrl.raw	<= 8'h00;			// All drive pins inactive
			step_rate		<= '0;
			step_go			<= 1'b0;
			sram_wr			<= 1'b0;
		end else begin
			step_go	<= host.wr && (host.addr == REG_STEP_CMD);
			sram_wr	<= host.wr && (host.addr == REG_SRAM_DATA);
			if (host.wr) begin
				case (host.addr)
					REG_DRIVE_CTRL:	drive_ctrl.raw	<= host.data;
					REG_STEP_RATE:	step_rate		<= host.data;
					default: ;						// Others handled below or elsewhere
				endcase
			end
		end
	end

	always_ff @(posedge CLK_MASTER) begin
		if (host.wr && (host.addr == REG_SCRATCH)) scratch <= host.data;
		if (host.wr && (host.addr == REG_STEP_CMD)) step_cmd <= step_cmd_t'(host.data);
	end

	//////////////////////////////
	// SRAM read latch
	// Frozen once 0x03 is addressed, reopened once the next byte is on the bus
	always_ff @(posedge CLK_MASTER) begin
		if (reset) rd_end_d <= '0;
		else rd_end_d <= {rd_end_d[0], host.rd_end && (host.addr == REG_SRAM_DATA)};
	end

	assign sram_rd_open = (host.addr != REG_SRAM_DATA) || rd_end_d[1];

	always_ff @(posedge CLK_MASTER) begin
		if (sram_rd_open) sram_rd_lat <= sram_dq_in;
	end

	//////////////////////////////
	// Readback
	always_comb begin
		case (host.addr)
			REG_SRAM_ADDR_LO:	pmd_out = sram_a[7:0];
			REG_SRAM_ADDR_HI:	pmd_out = sram_a[15:8];
			REG_SRAM_ADDR_UP:	pmd_out = {5'b00000, sram_a[18:16]};
			REG_SRAM_DATA:		pmd_out = sram_rd_lat;
			REG_DRIVE_CTRL:		pmd_out = MCO_TYPE[7:0];		// Type low on read
			REG_TYPE_HI:		pmd_out = MCO_TYPE[15:8];
			REG_VER_LO:			pmd_out = MCO_VERSION[7:0];
			REG_VER_HI:			pmd_out = MCO_VERSION[15:8];
			REG_STATUS:			pmd_out = {status, 2'b00};
			REG_SCRATCH:		pmd_out = scratch;
			REG_SCRATCH_INV:	pmd_out = ~scratch;
			REG_FIXED_55:		pmd_out = 8'h55;
			REG_FIXED_AA:		pmd_out = 8'hAA;
			REG_INDEX_HI:		pmd_out = index_period[15:8];
			REG_INDEX_LO:		pmd_out = index_period[7:0];	// Latched at high read
			default:			pmd_out = 8'h00;
		endcase
	end

	// Drive pins are active low
	assign fd_dens_out	= ~drive_ctrl.fields.density;
	assign fd_inuse		= ~drive_ctrl.fields.in_use;
	assign fd_drvsel	= ~drive_ctrl.fields.drv_sel;
	assign fd_motena	= ~drive_ctrl.fields.motor_en;
	assign fd_sidesel	= ~drive_ctrl.fields.side_sel;

	// Strobes come from separate synchronisers upstream
	a_wr_rd_exclusive: assert property (@(posedge CLK_MASTER) disable iff (reset)
		!(host.wr && host.rd_end));

endmodule

/* design/mcu_bus_interface.sv */
`timescale 1ns/1ns

module mcu_bus_interface import fdc_bus_pkg::*; (
	input	logic				CLK_MASTER,
	input	logic				reset,
	input	host_byte_t		pmd_in,			// Multiplexed address/data
	input	logic				pmall,			// Address latch enable
	input	logic				pmrd,
	input	logic				pmwr,
	output	host_access_t	host
);

	//////////////////////////////
	// Strobe synchronisers
	// Bit 1 is PMRD, bit 0 is PMWR
	logic [1:0]	lvl_meta;
	logic [1:0]	lvl_sync;
	logic [1:0]	lvl_prev;					// For edge detect
	logic			wr_pulse;
	logic			rd_end_pulse;
	reg_addr_e	addr_lat;

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			lvl_meta		<= '0;
			lvl_sync		<= '0;
			lvl_prev		<= '0;
			wr_pulse		<= 1'b0;
			rd_end_pulse	<= 1'b0;
		end else begin
			lvl_meta		<= {pmrd, pmwr};
			lvl_sync		<= lvl_meta;
			lvl_prev		<= lvl_sync;
			wr_pulse		<= lvl_sync[0] & ~lvl_prev[0];		// PMWR rising
			rd_end_pulse	<= ~lvl_sync[1] & lvl_prev[1];		// PMRD falling
		end
	end

	//////////////////////////////
	// Address latch
	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			addr_lat <= REG_SRAM_ADDR_LO;
		end else if (pmall) begin
			addr_lat <= reg_addr_e'(pmd_in);		// Any byte, unknown ones read as 0
		end
	end

	// Data is stable while PMWR is high, so it goes straight through
	assign host = '{
		wr:		wr_pulse,
		rd_end:	rd_end_pulse,
		addr:		addr_lat,
		data:		pmd_in
	};

endmodule

/* design/fdc_drive_pkg.sv */
package fdc_drive_pkg;

	localparam int SRAM_ADDR_W = 19;

	typedef logic [SRAM_ADDR_W-1:0] sram_addr_t;

	// Drive control byte
	// Written whole, decoded bit by bit onto the drive pins
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic			side_sel;		// Bit 7
			logic			motor_en;		// Bit 6
			logic [3:0]	drv_sel;			// Bits 5:2, one per drive
			logic			in_use;			// Bit 1
			logic			density;			// Bit 0
		} fields;
	} drive_ctrl_u;

	typedef struct packed {
		logic			inward;				// 1 steps towards the spindle
		logic [6:0]	count;				// Number of step pulses
	} step_cmd_t;

	// SRAM pins, all outputs
	typedef struct packed {
		sram_addr_t	addr;
		logic [7:0]	dq_out;				// Write data
		logic			we_n;
		logic			oe_n;
	} sram_bus_t;

	// Status register, upper six bits
	typedef struct packed {
		logic index;
		logic track0;
		logic wrprot;
		logic ready;
		logic density;
		logic stepping;
	} drive_status_t;

endpackage

/* design/fdc_bus_pkg.sv */
package fdc_bus_pkg;

	typedef logic [7:0] host_byte_t;		// One byte on the MCU data bus

	//////////////////////////////
	// Register map
	// Low address byte only
	typedef enum logic [7:0] {
		REG_SRAM_ADDR_LO	= 8'h00,		// SRAM address bits 7:0
		REG_SRAM_ADDR_HI	= 8'h01,		// SRAM address bits 15:8
		REG_SRAM_ADDR_UP	= 8'h02,		// SRAM address bits 18:16
		REG_SRAM_DATA		= 8'h03,		// SRAM data port
		REG_DRIVE_CTRL		= 8'h04,		// Drive control on write, type low on read
		REG_TYPE_HI			= 8'h05,
		REG_VER_LO			= 8'h06,
		REG_VER_HI			= 8'h07,
		REG_STATUS			= 8'h0F,
		REG_SCRATCH			= 8'h30,		// Bus test scratchpad
		REG_SCRATCH_INV	= 8'h31,		// Scratchpad inverted
		REG_FIXED_55		= 8'h32,
		REG_FIXED_AA		= 8'h33,
		REG_INDEX_HI		= 8'h40,		// Read first, latches the low byte
		REG_INDEX_LO		= 8'h41,
		REG_STEP_RATE		= 8'hF0,		// Step spacing in 250 us ticks
		REG_STEP_CMD		= 8'hFF			// Direction and count
	} reg_addr_e;

	// One bus access as the core sees it
	typedef struct packed {
		logic			wr;				// Write strobe, one cycle
		logic			rd_end;			// Read finished, one cycle
		reg_addr_e	addr;				// Latched register address
		host_byte_t	data;				// Byte from the MCU
	} host_access_t;

	localparam logic [15:0] MCO_TYPE		= 16'hDD55;		// Microcode type
	localparam logic [15:0] MCO_VERSION	= 16'h001F;		// Microcode version

endpackage
